//--- src/walk_snd_pkg.sv
package walk_snd_pkg;

    // ****************************************
    // fixed-point format
    // ****************************************
    localparam int sample_w = 16;        // signed audio samples, 2^14 is 12 V
    localparam int q15_one  = 32768;     // unity in the Q15 coefficients

    localparam logic signed [sample_w-1:0] five_volt_level = 16'sd6826; // 2^14 * 5/12
    localparam logic signed [sample_w-1:0] vco_gate_level  = 16'sd1000;

    // ****************************************
    // timing
    // ****************************************
    localparam logic [7:0] default_tick_div = 8'd21;   // 1 MHz clock over 48 kHz
    localparam logic [7:0] min_tick_div     = 8'd2;
    localparam int         integ_shift      = 3;       // integrator runs at fs / 8

    // inverter oscillator with 4.3k and 10u, half of 2.2 RC at 48 kHz
    localparam int sq_half_period = 2270;

    // ****************************************
    // Q15 smoothing factors, dt / (RC + dt)
    // ****************************************
    localparam int lp_ctrl_k = 171;      // 1.2k, 3.3u at fs
    localparam int hp_env_k  = 165;      // 10k, 3.3u at fs / 8
    localparam int hp_band_k = 26;       // 5.6k, 4.7u at fs
    localparam int lp_band_k = 2403;     // 5.6k, 47n at fs

    // 555 timing cap of 33n charged through 47k + 27k, discharged through 27k
    localparam int vco_charge_k    = 280;
    localparam int vco_discharge_k = 766;
    localparam int q15_third       = 10923;
    localparam int q15_two_thirds  = 21845;

    // two-way resistive mixer, 10k on the enable level and 12k on the square wave
    localparam int mix_en_k = 17873;     // 12 / 22
    localparam int mix_sq_k = 14895;     // 10 / 22

    // ****************************************
    // enums
    // ****************************************
    typedef enum logic [1:0] {
        addr_ctrl     = 2'd0,
        addr_volume   = 2'd1,
        addr_tick_div = 2'd2,
        addr_reserved = 2'd3
    } reg_addr_e;

    typedef enum logic {
        level_low  = 1'b0,
        level_high = 1'b1
    } osc_state_e;

endpackage

//--- src/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tick_div,
    output logic       audio_en,
    output logic       integ_en
);

    localparam int cnt_w = walk_snd_pkg::integ_shift;

    logic [7:0]       cnt;        // cycles left until the next sample strobe
    logic [cnt_w-1:0] sample_cnt;
    logic             expire;

    assign expire = (cnt <= 8'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= walk_snd_pkg::default_tick_div;
            sample_cnt <= '0;
            audio_en   <= 1'b0;
            integ_en   <= 1'b0;
        end else begin
            audio_en <= expire;
            integ_en <= expire && (sample_cnt == '0); // every 2^integ_shift samples
            if (expire) begin
                cnt        <= tick_div;
                sample_cnt <= sample_cnt + cnt_w'(1);
            end else begin
                cnt <= cnt - 8'd1;
            end
        end
    end

    a_strobe_gap: assert property (@(posedge clk) disable iff (!rst_n) audio_en |=> !audio_en);
    a_tick_min: assert property (@(posedge clk) disable iff (!rst_n)
        tick_div >= walk_snd_pkg::min_tick_div);

endmodule

//--- src/square_osc.sv
`timescale 1ns/1ps

module square_osc #(
    parameter int                                           half_period = walk_snd_pkg::sq_half_period,
    parameter logic signed [walk_snd_pkg::sample_w-1:0] high_level  = walk_snd_pkg::five_volt_level,
    parameter logic signed [walk_snd_pkg::sample_w-1:0] low_level   = '0
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      audio_en,
    output logic signed [walk_snd_pkg::sample_w-1:0] out
);

    localparam int cnt_w = $clog2(half_period + 1);

    walk_snd_pkg::osc_state_e state;
    walk_snd_pkg::osc_state_e state_next;
    logic [cnt_w-1:0]         cnt;       // samples spent in the current half period
    logic                     flip;

    assign flip = (cnt == cnt_w'(half_period - 1));

    always_comb begin
        state_next = state;
        if (flip) begin
            // the inverter swings once the capacitor crosses its threshold
            state_next = (state == walk_snd_pkg::level_high) ? walk_snd_pkg::level_low
                                                              : walk_snd_pkg::level_high;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= walk_snd_pkg::level_low;
            cnt   <= '0;
            out   <= low_level;
        end else if (audio_en) begin
            state <= state_next;
            cnt   <= flip ? '0 : cnt + cnt_w'(1);
            out   <= (state_next == walk_snd_pkg::level_high) ? high_level : low_level;
        end
    end

endmodule

//--- src/rc_filter.sv
`timescale 1ns/1ps

module rc_filter #(
    parameter int coef      = walk_snd_pkg::lp_ctrl_k, // Q15 smoothing factor
    parameter bit high_pass = 1'b0
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      en,
    input  logic signed [walk_snd_pkg::sample_w-1:0] in,
    output logic signed [walk_snd_pkg::sample_w-1:0] out
);

    localparam int w = walk_snd_pkg::sample_w;

    logic signed [w-1:0]  state;       // capacitor voltage of the low-pass section
    logic signed [w-1:0]  state_next;
    logic signed [w:0]    diff;
    logic signed [w+16:0] prod;
    logic signed [w:0]    step;
    logic signed [w:0]    hp_raw;
    logic signed [w-1:0]  hp_sat;
    logic signed [w-1:0]  y_next;

    always_comb begin
        diff = (w + 1)'(in) - (w + 1)'(state);
        prod = (w + 17)'(diff) * (w + 17)'(coef);
        step = (w + 1)'(prod / (w + 17)'(walk_snd_pkg::q15_one)); // truncates toward zero
        // never stall short of the input, otherwise small residues would stick forever
        if (step == '0 && diff != '0) begin
            step = (diff > 0) ? (w + 1)'(1) : -(w + 1)'(1);
        end
        state_next = w'((w + 1)'(state) + step);

        hp_raw = (w + 1)'(in) - (w + 1)'(state);
        if (hp_raw > (w + 1)'(32767)) begin
            hp_sat = 16'sh7fff;
        end else if (hp_raw < -(w + 1)'(32768)) begin
            hp_sat = 16'sh8000;
        end else begin
            hp_sat = w'(hp_raw);
        end

        y_next = high_pass ? hp_sat : state_next;
    end

    // ****************************************
    // state and output advance together
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= '0;
            out   <= '0;
        end else if (en) begin
            state <= state_next;
            out   <= y_next;
        end
    end

endmodule

//--- src/vco_555.sv
`timescale 1ns/1ps

module vco_555 #(
    parameter int charge_k    = walk_snd_pkg::vco_charge_k,
    parameter int discharge_k = walk_snd_pkg::vco_discharge_k,
    parameter logic signed [walk_snd_pkg::sample_w-1:0] high_level = walk_snd_pkg::five_volt_level
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      audio_en,
    input  logic signed [walk_snd_pkg::sample_w-1:0] v_control,
    output logic signed [walk_snd_pkg::sample_w-1:0] out
);

    localparam int w = walk_snd_pkg::sample_w;

    walk_snd_pkg::osc_state_e state;      // level_high while the capacitor charges
    walk_snd_pkg::osc_state_e state_next;
    logic signed [w-1:0]      v_cap;
    logic signed [w-1:0]      v_cap_next;
    logic signed [w-1:0]      v_upper;
    logic signed [w-1:0]      v_lower;
    logic signed [w+16:0]     upper_prod;
    logic signed [w+16:0]     lower_prod;
    logic signed [w:0]        diff;
    logic signed [w+16:0]     prod;
    logic signed [w:0]        step;

    always_comb begin
        // comparator thresholds follow the control voltage
        upper_prod = (w + 17)'(v_control) * (w + 17)'(walk_snd_pkg::q15_two_thirds);
        lower_prod = (w + 17)'(v_control) * (w + 17)'(walk_snd_pkg::q15_third);
        v_upper    = w'(upper_prod >>> 15);
        v_lower    = w'(lower_prod >>> 15);

        if (state == walk_snd_pkg::level_high) begin
            diff = (w + 1)'(high_level) - (w + 1)'(v_cap); // charge toward the supply
            prod = (w + 17)'(diff) * (w + 17)'(charge_k);
        end else begin
            diff = -(w + 1)'(v_cap);                        // discharge toward ground
            prod = (w + 17)'(diff) * (w + 17)'(discharge_k);
        end
        step = (w + 1)'(prod / (w + 17)'(walk_snd_pkg::q15_one));
        if (step == '0 && diff != '0) begin
            step = (diff > 0) ? (w + 1)'(1) : -(w + 1)'(1);
        end
        v_cap_next = w'((w + 1)'(v_cap) + step);

        state_next = state;
        if (state == walk_snd_pkg::level_high && v_cap_next >= v_upper) begin
            state_next = walk_snd_pkg::level_low;
        end else if (state == walk_snd_pkg::level_low && v_cap_next <= v_lower) begin
            state_next = walk_snd_pkg::level_high;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= walk_snd_pkg::level_high;
            v_cap <= '0;
            out   <= '0;
        end else if (audio_en) begin
            state <= state_next;
            v_cap <= v_cap_next;
            out   <= (state_next == walk_snd_pkg::level_high) ? high_level : '0;
        end
    end

    // the capacitor never leaves the span between ground and the supply
    a_cap_range: assert property (@(posedge clk) disable iff (!rst_n)
        v_cap >= 0 && v_cap <= high_level);

endmodule

//--- src/walk_cfg_regs.sv
`timescale 1ns/1ps

module walk_cfg_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        reg_wr,
    input  logic [1:0]  reg_addr,
    input  logic [15:0] reg_wdata,
    output logic [15:0] reg_rdata,
    output logic        walk_en,
    output logic [3:0]  vol_shift,
    output logic [7:0]  tick_div
);

    walk_snd_pkg::reg_addr_e addr;

    assign addr = walk_snd_pkg::reg_addr_e'(reg_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            walk_en   <= 1'b0;
            vol_shift <= 4'd0;
            tick_div  <= walk_snd_pkg::default_tick_div;
        end else if (reg_wr) begin
            case (addr)
                walk_snd_pkg::addr_ctrl:   walk_en   <= reg_wdata[0];
                walk_snd_pkg::addr_volume: vol_shift <= reg_wdata[3:0];
                walk_snd_pkg::addr_tick_div: begin
                    // periods below the minimum would make strobes touch
                    if (reg_wdata[7:0] < walk_snd_pkg::min_tick_div) begin
                        tick_div <= walk_snd_pkg::min_tick_div;
                    end else begin
                        tick_div <= reg_wdata[7:0];
                    end
                end
                default: ; // writes to the reserved slot are dropped
            endcase
        end
    end

    always_comb begin
        case (addr)
            walk_snd_pkg::addr_ctrl:     reg_rdata = {15'd0, walk_en};
            walk_snd_pkg::addr_volume:   reg_rdata = {12'd0, vol_shift};
            walk_snd_pkg::addr_tick_div: reg_rdata = {8'd0, tick_div};
            default:                     reg_rdata = 16'd0;
        endcase
    end

endmodule

//--- src/dk_walk.sv
`timescale 1ns/1ps

module dk_walk (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      audio_en,
    input  logic                                      integ_en,
    input  logic                                      walk_en,
    output logic signed [walk_snd_pkg::sample_w-1:0] out
);

    localparam int w = walk_snd_pkg::sample_w;

    logic signed [w-1:0]  en_level;     // walk enable as a 5 V logic level
    logic signed [w-1:0]  sq_out;
    logic signed [w+16:0] mix_prod;
    logic signed [w-1:0]  v_mix;
    logic signed [w-1:0]  v_ctrl;
    logic signed [w-1:0]  vco_out;
    logic                 gate_open;
    logic signed [w-1:0]  env_hp;
    logic signed [w-1:0]  enveloped;
    logic signed [w-1:0]  band_hp;
    logic signed [w-1:0]  band_lp;

    assign en_level = walk_en ? walk_snd_pkg::five_volt_level : '0;

    square_osc u_square (.clk(clk), .rst_n(rst_n), .audio_en(audio_en), .out(sq_out));

    // ****************************************
    // control voltage for the 555
    // ****************************************
    assign mix_prod = (w + 17)'(en_level) * (w + 17)'(walk_snd_pkg::mix_en_k)
                    + (w + 17)'(sq_out) * (w + 17)'(walk_snd_pkg::mix_sq_k);
    assign v_mix    = w'(mix_prod >>> 15);

    rc_filter #(.coef(walk_snd_pkg::lp_ctrl_k), .high_pass(1'b0)) u_lp_ctrl (
        .clk(clk), .rst_n(rst_n), .en(audio_en), .in(v_mix), .out(v_ctrl)
    );

    vco_555 u_vco (
        .clk(clk), .rst_n(rst_n), .audio_en(audio_en), .v_control(v_ctrl), .out(vco_out)
    );

    // ****************************************
    // envelope, gated by the 555
    // ****************************************
    assign gate_open = (vco_out > walk_snd_pkg::vco_gate_level);

    // the coupling cap only sees current while the 555 output is high
    rc_filter #(.coef(walk_snd_pkg::hp_env_k), .high_pass(1'b1)) u_hp_env (
        .clk(clk), .rst_n(rst_n), .en(integ_en && gate_open), .in(en_level), .out(env_hp)
    );

    assign enveloped = gate_open ? env_hp : '0;

    // band limit of the gated pulses
    rc_filter #(.coef(walk_snd_pkg::hp_band_k), .high_pass(1'b1)) u_hp_band (
        .clk(clk), .rst_n(rst_n), .en(audio_en), .in(enveloped), .out(band_hp)
    );

    rc_filter #(.coef(walk_snd_pkg::lp_band_k), .high_pass(1'b0)) u_lp_band (
        .clk(clk), .rst_n(rst_n), .en(audio_en), .in(band_hp), .out(band_lp)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else if (audio_en) begin
            out <= band_lp; // one strobe behind the band-pass stage
        end
    end

endmodule

//--- src/walk_sound_top.sv
`timescale 1ns/1ps

module walk_sound_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      reg_wr,
    input  logic [1:0]                                reg_addr,
    input  logic [15:0]                               reg_wdata,
    output logic [15:0]                               reg_rdata,
    output logic                                      sample_valid,
    output logic signed [walk_snd_pkg::sample_w-1:0] sample_out
);

    logic                                      walk_en;
    logic [3:0]                                vol_shift;
    logic [7:0]                                tick_div;
    logic                                      audio_en;
    logic                                      integ_en;
    logic signed [walk_snd_pkg::sample_w-1:0] walk_out;
    logic signed [walk_snd_pkg::sample_w-1:0] scaled;

    walk_cfg_regs u_regs (
        .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .walk_en(walk_en),
        .vol_shift(vol_shift), .tick_div(tick_div)
    );

    sample_tick_gen u_tick (
        .clk(clk), .rst_n(rst_n), .tick_div(tick_div), .audio_en(audio_en), .integ_en(integ_en)
    );

    dk_walk u_walk (
        .clk(clk), .rst_n(rst_n), .audio_en(audio_en), .integ_en(integ_en),
        .walk_en(walk_en), .out(walk_out)
    );

    // a full shift would leave -1 on negative samples, so the top step mutes
    assign scaled = (vol_shift == 4'hf) ? '0 : (walk_out >>> vol_shift);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
            sample_out   <= '0;
        end else begin
            sample_valid <= audio_en;
            if (audio_en) begin
                sample_out <= scaled; // visible together with sample_valid
            end
        end
    end

endmodule

//--- dv/walk_sound_tb.sv
`timescale 1ns/1ps

module walk_sound_tb;

    logic                                      clk;
    logic                                      rst_n;
    logic                                      reg_wr;
    logic [1:0]                                reg_addr;
    logic [15:0]                               reg_wdata;
    logic [15:0]                               reg_rdata;
    logic                                      sample_valid;
    logic signed [walk_snd_pkg::sample_w-1:0] sample_out;

    integer      seed;
    int          value_errs;
    int          stable_errs;
    int          tests_run;
    int          tests_failed;
    logic        rd_chk;       // readback compare armed for this cycle
    logic [15:0] rd_exp;
    logic        gap_chk;      // strobe spacing compare armed
    logic [15:0] gap;
    logic [15:0] tick_exp;
    logic        quiet_chk;    // every strobed sample must be zero

    walk_sound_top DUT (
        .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .sample_valid(sample_valid), .sample_out(sample_out)
    );

    always #10 clk = ~clk;

    // cycles since the previous output strobe
    always_ff @(posedge clk) begin
        if (!rst_n || sample_valid) begin
            gap <= 16'd1;
        end else if (gap != 16'hffff) begin
            gap <= gap + 16'd1;
        end
    end

    // ****************************************
    // checks
    // ****************************************
    a_readback: assert property (@(posedge clk) disable iff (!rst_n)
        rd_chk |-> reg_rdata == rd_exp)
        else begin
            $display("ERR %0t: readback 0x%04h, expected 0x%04h",
                     $time, $sampled(reg_rdata), rd_exp);
            value_errs++;
        end

    a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        gap_chk && sample_valid |-> gap == tick_exp)
        else begin
            $display("ERR %0t: strobes %0d cycles apart, expected %0d",
                     $time, $sampled(gap), tick_exp);
            value_errs++;
        end

    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !sample_valid |-> $stable(sample_out))
        else begin
            $display("ERR %0t: sample_out changed without sample_valid", $time);
            stable_errs++;
        end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        quiet_chk && sample_valid |-> sample_out == '0)
        else begin
            $display("ERR %0t: sample %0d where silence is expected",
                     $time, $sampled(sample_out));
            value_errs++;
        end

    // ****************************************
    // helpers
    // ****************************************
    task automatic next_cycle();
        @(posedge clk);
        #1; // outputs settled, inputs change here
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle();
        reg_wr = 1'b0;
    endtask

    task automatic expect_read(input logic [1:0] addr, input logic [15:0] exp);
        reg_addr = addr;
        rd_exp   = exp;
        rd_chk   = 1'b1;
        next_cycle();
        rd_chk = 1'b0;
    endtask

    // writes below two are stored as two, only the low byte is kept
    function automatic logic [15:0] clamped_period(input logic [15:0] data);
        return (data[7:0] < 8'd2) ? 16'd2 : {8'd0, data[7:0]};
    endfunction

    task automatic wait_strobes(input int n, output bit ok);
        int cycles;
        ok = 1'b1;
        for (int i = 0; i < n && ok; i++) begin
            cycles = 0;
            do begin
                next_cycle();
                cycles++;
            end while (!sample_valid && cycles < 600);
            if (!sample_valid) begin
                $display("timeout at %0t: no sample strobe within 600 cycles", $time);
                ok = 1'b0;
            end
        end
    endtask

    task automatic wait_nonzero(input int max_samples, output bit ok);
        bit strobe_ok;
        int count;
        count     = 0;
        ok        = 1'b0;
        strobe_ok = 1'b1;
        while (!ok && strobe_ok && count < max_samples) begin
            wait_strobes(1, strobe_ok);
            count++;
            ok = strobe_ok && (sample_out != '0);
        end
        if (!ok) $display("no nonzero sample appeared within %0d samples", max_samples);
    endtask

    task automatic wait_quiet_run(input int run_len, input int max_samples, output bit ok);
        bit strobe_ok;
        int count;
        int run;
        count     = 0;
        run       = 0;
        strobe_ok = 1'b1;
        while (strobe_ok && run < run_len && count < max_samples) begin
            wait_strobes(1, strobe_ok);
            count++;
            run = (sample_out == '0) ? run + 1 : 0;
        end
        ok = strobe_ok && (run >= run_len);
        if (!ok) $display("output did not settle at zero within %0d samples", max_samples);
    endtask

    task automatic report_test(input string name, input int fails, input bit ok);
        tests_run++;
        if (fails == 0 && ok) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d check errors", name, fails);
        end
    endtask

    initial begin
        bit          ok;
        int          errs;
        int          period;
        logic [31:0] rnd;
        seed = 10741;
        clk = 1'b0;
        rst_n = 1'b0;
        reg_wr = 1'b0;
        reg_addr = 2'd0;
        reg_wdata = 16'd0;
        rd_chk = 1'b0;
        rd_exp = 16'd0;
        gap_chk = 1'b0;
        tick_exp = 16'd21;
        quiet_chk = 1'b0;
        value_errs = 0;
        stable_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // walk_en has never been set, so the chain holds at zero
        errs = value_errs;
        quiet_chk = 1'b1;
        wait_strobes(300, ok);
        quiet_chk = 1'b0;
        report_test("silence", value_errs - errs, ok);

        errs = value_errs;
        write_reg(walk_snd_pkg::addr_ctrl, 16'hfffe);
        expect_read(walk_snd_pkg::addr_ctrl, 16'h0000);
        write_reg(walk_snd_pkg::addr_ctrl, 16'hffff);
        expect_read(walk_snd_pkg::addr_ctrl, 16'h0001);
        write_reg(walk_snd_pkg::addr_ctrl, 16'h0000);
        expect_read(walk_snd_pkg::addr_ctrl, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            write_reg(walk_snd_pkg::addr_volume, rnd[15:0]);
            expect_read(walk_snd_pkg::addr_volume, {12'd0, rnd[3:0]});
        end
        for (int i = 0; i < 4; i++) begin
            rnd = (i < 2) ? 32'(i) : $random(seed); // zero and one land on the clamp
            write_reg(walk_snd_pkg::addr_tick_div, rnd[15:0]);
            expect_read(walk_snd_pkg::addr_tick_div, clamped_period(rnd[15:0]));
        end
        write_reg(walk_snd_pkg::addr_reserved, 16'hffff);
        expect_read(walk_snd_pkg::addr_reserved, 16'h0000);
        report_test("register readback", value_errs - errs, 1'b1);

        // ****************************************
        // strobe spacing
        // ****************************************
        errs = value_errs;
        ok = 1'b1;
        for (int i = 0; i < 9 && ok; i++) begin
            period = (i == 0) ? 21 : 2 + int'($unsigned($random(seed)) % 39);
            write_reg(walk_snd_pkg::addr_tick_div, 16'(period));
            tick_exp = 16'(period);
            wait_strobes(3, ok); // the countdown in flight may still use the old period
            gap_chk = ok;
            if (ok) wait_strobes(6, ok);
            gap_chk = 1'b0;
        end
        report_test("strobe spacing", value_errs - errs, ok);

        errs = value_errs;
        write_reg(walk_snd_pkg::addr_tick_div, 16'd2);
        write_reg(walk_snd_pkg::addr_volume, 16'd0);
        write_reg(walk_snd_pkg::addr_ctrl, 16'd1);
        wait_nonzero(4000, ok);
        if (ok) wait_strobes(2000, ok);
        write_reg(walk_snd_pkg::addr_ctrl, 16'd0);
        if (ok) wait_quiet_run(1000, 400000, ok);
        quiet_chk = ok;
        if (ok) wait_strobes(3000, ok);
        quiet_chk = 1'b0;
        report_test("sound and decay", value_errs - errs, ok);

        errs = value_errs;
        write_reg(walk_snd_pkg::addr_volume, 16'd15);
        wait_strobes(2, ok);
        quiet_chk = ok;
        write_reg(walk_snd_pkg::addr_ctrl, 16'd1);
        if (ok) wait_strobes(3000, ok);
        quiet_chk = 1'b0;
        write_reg(walk_snd_pkg::addr_volume, 16'd0);
        if (ok) wait_nonzero(4000, ok);
        write_reg(walk_snd_pkg::addr_ctrl, 16'd0);
        report_test("muting", value_errs - errs, ok);

        report_test("stable output", stable_errs, 1'b1);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && value_errs == 0 && stable_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- walk_sound_top.f
src/walk_snd_pkg.sv
src/sample_tick_gen.sv
src/square_osc.sv
src/rc_filter.sv
src/vco_555.sv
src/walk_cfg_regs.sv
src/dk_walk.sv
src/walk_sound_top.sv
dv/walk_sound_tb.sv

//--- Makefile
# Verilator build and run of the walk sound testbench

VERILATOR ?= verilator
TOP       ?= walk_sound_tb
FILELIST  ?= walk_sound_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the recipe fails unless the pass message shows up on a line of its own
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
